// File: design/branch_defines.svh
`ifndef BRANCH_DEFINES_SVH
`define BRANCH_DEFINES_SVH

// Datapath width, every PC and target is this wide
`define ADDR_W     16

// Table sizing, index taken from pc bits just above bit 0
`define BHT_IDX_W  4        // 16 counters
`define BTB_IDX_W  4        // 16 entries, tag is the rest of the pc

// 2-bit counter state after reset, weakly not taken
`define BHT_INIT   2'b01

// Branch opcodes in instr[15:12]
`define OP_B       4'b1100  // PC-relative, 9-bit offset
`define OP_BR      4'b1101  // Register target from Rs

`endif

// File: design/branch_pkg.sv
`default_nettype none

`include "branch_defines.svh"

package branch_pkg;

  // Condition flags from the ALU, Z V N order as in the flag register
  typedef struct packed {
    logic z;  // Zero
    logic v;  // Overflow
    logic n;  // Negative
  } flags_t;

  // Condition code field, bits [11:9] of a branch
  typedef enum logic [2:0] {
    NEQ    = 3'd0,
    EQ     = 3'd1,
    GT     = 3'd2,
    LT     = 3'd3,
    GTE    = 3'd4,
    LTE    = 3'd5,
    OVFL   = 3'd6,
    UNCOND = 3'd7
  } cond_e;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction formats
  ////////////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic [3:0]        opcode;  // 1100
    cond_e             cond;
    logic signed [8:0] imm;     // Halfword offset
  } b_fmt_t;

  typedef struct packed {
    logic [3:0] opcode;   // 1101
    cond_e      cond;
    logic       pad_hi;   // Unused bit 8
    logic [3:0] rs;       // Target register
    logic [3:0] pad_lo;   // Unused low nibble
  } br_fmt_t;

  // Same 16-bit word, format picked by opcode in decode
  typedef union packed {
    b_fmt_t  b;
    br_fmt_t br;
  } instr_u;

  ////////////////////////////////////////////////////////////////////////////
  // Table lookup and update records
  ////////////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic               wen;    // One-cycle write strobe
    logic [`ADDR_W-1:0] pc;     // Branch address
    logic               taken;  // Resolved direction
  } bht_upd_t;

  typedef struct packed {
    logic               wen;
    logic [`ADDR_W-1:0] pc;
    logic [`ADDR_W-1:0] target;  // Resolved taken target
  } btb_upd_t;

  typedef struct packed {
    logic               hit;     // Valid and tag match
    logic [`ADDR_W-1:0] target;
  } btb_look_t;

endpackage

`default_nettype wire

// File: design/branch_history_table.sv
`timescale 1ns/1ps
`default_nettype none

`include "branch_defines.svh"

// Direction predictor, one 2-bit saturating counter per index
module branch_history_table (
  input  wire                    clk,
  input  wire                    rst,
  input  wire [`ADDR_W-1:0]      fetch_pc,   // Lookup address from fetch
  input  wire branch_pkg::bht_upd_t upd,     // Resolved outcome from decode
  output logic                   pred_taken
);

  localparam int DEPTH = 2 ** `BHT_IDX_W;

  logic [1:0] cnt_q [DEPTH];       // Counter array

  logic [`BHT_IDX_W-1:0] rd_idx;   // Fetch side index
  logic [`BHT_IDX_W-1:0] wr_idx;   // Update side index
  logic [1:0]            cur_cnt;  // Counter at the update index
  logic [1:0]            nxt_cnt;  // Counter after the update

  // Bit 0 is always zero for halfword-aligned code, skip it
  assign rd_idx = fetch_pc[`BHT_IDX_W:1];
  assign wr_idx = upd.pc[`BHT_IDX_W:1];

  // Lookup is pure read, a same-cycle write is not forwarded
  assign pred_taken = cnt_q[rd_idx][1];  // MSB set means taken

  ////////////////////////////////////////////////////////////////////////////
  // Saturating counter step
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    cur_cnt = cnt_q[wr_idx];
    nxt_cnt = cur_cnt;                     // Hold when saturated
    if (upd.taken) begin
      if (cur_cnt != 2'b11)
        nxt_cnt = cur_cnt + 2'd1;          // Toward strongly taken
    end else begin
      if (cur_cnt != 2'b00)
        nxt_cnt = cur_cnt - 2'd1;          // Toward strongly not taken
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        cnt_q[i] <= `BHT_INIT;             // Weakly not taken
      end
    end else if (upd.wen) begin
      cnt_q[wr_idx] <= nxt_cnt;
    end
  end

  // Decode must never leave the strobe floating once out of reset
  a_upd_wen_known : assert property (
    @(posedge clk) disable iff (rst) !$isunknown(upd.wen)
  ) else $error("BHT update strobe unknown");

endmodule

`default_nettype wire

// File: design/branch_target_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "branch_defines.svh"

// Direct-mapped target cache, valid bit plus tag plus full target per entry
module branch_target_buffer (
  input  wire                    clk,
  input  wire                    rst,
  input  wire [`ADDR_W-1:0]      fetch_pc,
  input  wire branch_pkg::btb_upd_t upd,     // Fill request from decode
  output branch_pkg::btb_look_t  look        // Hit and stored target
);

  localparam int DEPTH = 2 ** `BTB_IDX_W;
  localparam int TAG_W = `ADDR_W - `BTB_IDX_W - 1;  // Bit 0 not stored

  logic             valid_q [DEPTH];   // Cleared on reset
  logic [TAG_W-1:0] tag_q   [DEPTH];   // Payload, no reset
  logic [`ADDR_W-1:0] tgt_q [DEPTH];   // Payload, no reset

  logic [`BTB_IDX_W-1:0] rd_idx;
  logic [TAG_W-1:0]      rd_tag;
  logic [`BTB_IDX_W-1:0] wr_idx;
  logic [TAG_W-1:0]      wr_tag;

  ////////////////////////////////////////////////////////////////////////////
  // Address split
  ////////////////////////////////////////////////////////////////////////////
  assign rd_idx = fetch_pc[`BTB_IDX_W:1];
  assign rd_tag = fetch_pc[`ADDR_W-1:`BTB_IDX_W+1];
  assign wr_idx = upd.pc[`BTB_IDX_W:1];
  assign wr_tag = upd.pc[`ADDR_W-1:`BTB_IDX_W+1];

  // Combinational lookup, returns pre-write contents on a same-cycle fill
  always_comb begin
    look.hit    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    look.target = tgt_q[rd_idx];   // Only meaningful with hit
  end

  // Valid bits carry the control state
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else if (upd.wen) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  // A fill overwrites whatever pc owned the slot before
  always_ff @(posedge clk) begin
    if (upd.wen) begin
      tag_q[wr_idx] <= wr_tag;
      tgt_q[wr_idx] <= upd.target;
    end
  end

  // Instructions are 16-bit, so a stored target must be halfword aligned
  a_fill_aligned : assert property (
    @(posedge clk) disable iff (rst) upd.wen |-> (upd.target[0] == 1'b0)
  ) else $error("BTB fill with odd target %h", upd.target);

endmodule

`default_nettype wire

// File: design/fetch_predictor.sv
`timescale 1ns/1ps
`default_nettype none

`include "branch_defines.svh"

// Fetch-side next PC choice from the BHT direction and the BTB target
module fetch_predictor (
  input  wire [`ADDR_W-1:0]      fetch_pc,
  input  wire                    bht_taken,     // Counter MSB
  input  wire branch_pkg::btb_look_t btb_look,  // Target lookup result
  output logic                   pred_taken,
  output logic [`ADDR_W-1:0]     pred_next_pc
);

  logic [`ADDR_W-1:0] seq_pc;   // Fall-through address

  // Next halfword
  assign seq_pc = fetch_pc + `ADDR_W'(2);

  ////////////////////////////////////////////////////////////////////////////
  // Prediction
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    // Taken needs both a taken counter and a known target
    pred_taken = bht_taken & btb_look.hit;

    if (pred_taken)
      pred_next_pc = btb_look.target;  // Redirect fetch to cached target
    else
      pred_next_pc = seq_pc;           // Keep streaming
  end

endmodule

`default_nettype wire

// File: design/branch_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "branch_defines.svh"

// Decode-stage branch resolution and predictor training
module branch_control (
  input  wire                      clk,             // Assertions only
  input  wire                      rst,
  input  wire                      id_valid,
  input  wire [`ADDR_W-1:0]        id_pc,           // Address of the decoded instr
  input  wire branch_pkg::instr_u  id_instr,
  input  wire branch_pkg::flags_t  id_flags,
  input  wire [`ADDR_W-1:0]        id_rs_data,      // BR target register
  input  wire [`ADDR_W-1:0]        id_pred_next_pc, // What fetch chose after it
  output logic [`ADDR_W-1:0]       actual_next_pc,
  output logic                     redirect,
  output branch_pkg::bht_upd_t     bht_upd,
  output branch_pkg::btb_upd_t     btb_upd
);

  import branch_pkg::*;

  logic               is_b;         // PC-relative branch
  logic               is_br;        // Register branch
  logic               is_branch;    // Valid branch in decode
  logic               cond_met;     // Condition code satisfied
  logic               taken;        // Branch and condition met
  logic [`ADDR_W-1:0] seq_pc;       // id_pc + 2
  logic [`ADDR_W-1:0] offset;       // Sign-extended byte offset
  logic [`ADDR_W-1:0] target;       // Taken destination
  logic               upd_ok;       // Strobes allowed out of reset

  ////////////////////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////////////////////
  assign is_b      = (id_instr.b.opcode == `OP_B);
  assign is_br     = (id_instr.b.opcode == `OP_BR);   // Opcode at same bits
  assign is_branch = id_valid & (is_b | is_br);
  assign upd_ok    = ~rst;

  // Condition code against Z V N
  always_comb begin
    unique case (id_instr.b.cond)
      NEQ:     cond_met = ~id_flags.z;
      EQ:      cond_met =  id_flags.z;
      GT:      cond_met = ~id_flags.z & ~id_flags.n;
      LT:      cond_met =  id_flags.n;
      GTE:     cond_met =  id_flags.z | (~id_flags.z & ~id_flags.n);
      LTE:     cond_met =  id_flags.z | id_flags.n;
      OVFL:    cond_met =  id_flags.v;
      UNCOND:  cond_met = 1'b1;
      default: cond_met = 1'b0;   // Unreachable, all codes listed
    endcase
  end

  assign taken = is_branch & cond_met;

  ////////////////////////////////////////////////////////////////////////////
  // Target and next PC
  ////////////////////////////////////////////////////////////////////////////
  assign seq_pc = id_pc + `ADDR_W'(2);

  // imm counts halfwords, so shift in a zero after sign extension
  assign offset = {{(`ADDR_W-10){id_instr.b.imm[8]}}, id_instr.b.imm, 1'b0};

  assign target = is_br ? id_rs_data : (seq_pc + offset);  // BR takes Rs as is

  assign actual_next_pc = taken ? target : seq_pc;

  // Fetch guessed wrong direction or wrong target
  assign redirect = upd_ok & is_branch & (actual_next_pc != id_pred_next_pc);

  ////////////////////////////////////////////////////////////////////////////
  // Table training
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    bht_upd.wen   = upd_ok & is_branch;   // Every branch trains direction
    bht_upd.pc    = id_pc;
    bht_upd.taken = taken;

    // Fill only on a taken branch whose target fetch did not already follow
    btb_upd.wen    = upd_ok & taken & (target != id_pred_next_pc);
    btb_upd.pc     = id_pc;
    btb_upd.target = target;
  end

  // A register branch must land on a halfword boundary
  a_br_target_aligned : assert property (
    @(posedge clk) disable iff (rst) (taken && is_br) |-> (id_rs_data[0] == 1'b0)
  ) else $error("Taken BR to odd target %h", id_rs_data);

  // Fetch only ever follows halfword-aligned addresses
  a_pred_pc_aligned : assert property (
    @(posedge clk) disable iff (rst) id_valid |-> (id_pred_next_pc[0] == 1'b0)
  ) else $error("Odd predicted next pc %h in decode", id_pred_next_pc);

endmodule

`default_nettype wire

// File: design/branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "branch_defines.svh"

// Branch prediction and resolution top, fetch side plus decode side
module branch_unit (
  input  wire                      clk,
  input  wire                      rst,
  // Fetch
  input  wire [`ADDR_W-1:0]        fetch_pc,
  output logic                     pred_taken,
  output logic [`ADDR_W-1:0]       pred_next_pc,
  // Decode
  input  wire                      id_valid,
  input  wire [`ADDR_W-1:0]        id_pc,
  input  wire branch_pkg::instr_u  id_instr,
  input  wire branch_pkg::flags_t  id_flags,
  input  wire [`ADDR_W-1:0]        id_rs_data,
  input  wire [`ADDR_W-1:0]        id_pred_next_pc,
  output logic [`ADDR_W-1:0]       actual_next_pc,
  output logic                     redirect
);

  import branch_pkg::*;

  logic      bht_taken;   // Direction from the counters
  btb_look_t btb_look;    // Target lookup
  bht_upd_t  bht_upd;     // Decode to BHT
  btb_upd_t  btb_upd;     // Decode to BTB

  ////////////////////////////////////////////////////////////////////////////
  // Fetch side, both tables see fetch_pc in parallel
  ////////////////////////////////////////////////////////////////////////////
  branch_history_table u_bht (
    .clk        (clk),
    .rst        (rst),
    .fetch_pc   (fetch_pc),
    .upd        (bht_upd),
    .pred_taken (bht_taken)
  );

  branch_target_buffer u_btb (
    .clk      (clk),
    .rst      (rst),
    .fetch_pc (fetch_pc),
    .upd      (btb_upd),
    .look     (btb_look)
  );

  fetch_predictor u_fetch_pred (
    .fetch_pc     (fetch_pc),
    .bht_taken    (bht_taken),
    .btb_look     (btb_look),
    .pred_taken   (pred_taken),
    .pred_next_pc (pred_next_pc)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Decode side
  ////////////////////////////////////////////////////////////////////////////
  branch_control u_branch_ctrl (
    .clk             (clk),
    .rst             (rst),
    .id_valid        (id_valid),
    .id_pc           (id_pc),
    .id_instr        (id_instr),
    .id_flags        (id_flags),
    .id_rs_data      (id_rs_data),
    .id_pred_next_pc (id_pred_next_pc),
    .actual_next_pc  (actual_next_pc),
    .redirect        (redirect),
    .bht_upd         (bht_upd),   // Trains u_bht
    .btb_upd         (btb_upd)    // Fills u_btb
  );

endmodule

`default_nettype wire

// File: test/branch_checker.sv
`timescale 1ns/1ps
`default_nettype none

// Compares DUT outputs with the model on each rising edge out of reset
module branch_checker (
  input  wire        clk,
  input  wire        rst,
  // DUT side
  input  wire        pred_taken,
  input  wire [15:0] pred_next_pc,
  input  wire [15:0] actual_next_pc,
  input  wire        redirect,
  // Model side
  input  wire        exp_pred_taken,
  input  wire [15:0] exp_pred_next_pc,
  input  wire [15:0] exp_actual_next_pc,
  input  wire        exp_redirect,
  // Totals for the closing line
  output int         err_cnt,
  output int         check_cnt,      // Cycles compared
  output int         taken_cnt,      // Cycles with a taken prediction
  output int         redirect_cnt
);

  // One field, reported with time on mismatch or X
  task automatic compare_field(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("FAIL @%0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Sampling
  ////////////////////////////////////////////////////////////////////////////
  // Inputs change on the falling edge, so everything is settled here
  always @(posedge clk) begin
    if (rst) begin
      err_cnt      = 0;
      check_cnt    = 0;
      taken_cnt    = 0;
      redirect_cnt = 0;
    end else begin
      check_cnt++;
      // Fetch side
      compare_field("pred_taken", {15'd0, pred_taken}, {15'd0, exp_pred_taken});
      compare_field("pred_next_pc", pred_next_pc, exp_pred_next_pc);
      // Decode side
      compare_field("actual_next_pc", actual_next_pc, exp_actual_next_pc);
      compare_field("redirect", {15'd0, redirect}, {15'd0, exp_redirect});
      if (pred_taken === 1'b1)
        taken_cnt++;          // Shows the tables trained at all
      if (redirect === 1'b1)
        redirect_cnt++;
    end
  end

endmodule

`default_nettype wire

// File: test/tb_branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "branch_defines.svh"

module tb_branch_unit;

  localparam int          N_CYCLES       = 3000;  // Decode cycles after reset
  localparam int          RST_CYCLES     = 5;
  localparam int          TIMEOUT_CYCLES = N_CYCLES + RST_CYCLES + 100;
  localparam int          BHT_N          = 2 ** `BHT_IDX_W;
  localparam int          BTB_N          = 2 ** `BTB_IDX_W;
  localparam int          TAG_W          = `ADDR_W - `BTB_IDX_W - 1;
  localparam logic [1:0]  CNT_INIT       = 2'b01;         // Weakly not taken
  localparam logic [15:0] LFSR_SEED      = 16'd51219;
  localparam logic [15:0] LFSR_TAPS      = 16'hB400;      // x^16+x^14+x^13+x^11+1

  logic               clk = 1'b0;
  logic               rst;
  logic [`ADDR_W-1:0] fetch_pc;
  logic               pred_taken;
  logic [`ADDR_W-1:0] pred_next_pc;
  logic               id_valid;
  logic [`ADDR_W-1:0] id_pc;
  logic [15:0]        id_instr;          // Raw word, B or BR or other
  logic [2:0]         id_flags;          // Z V N
  logic [`ADDR_W-1:0] id_rs_data;
  logic [`ADDR_W-1:0] id_pred_next_pc;
  logic [`ADDR_W-1:0] actual_next_pc;
  logic               redirect;

  logic [15:0]        lfsr_state;
  logic [2:0]         fetch_idx;         // Pool slot of fetch_pc
  int                 cycle_cnt = 0;
  int                 err_cnt;
  int                 check_cnt;
  int                 taken_cnt;
  int                 redirect_cnt;

  // Reference tables
  logic [1:0]         m_cnt   [BHT_N];
  logic               m_valid [BTB_N];
  logic [TAG_W-1:0]   m_tag   [BTB_N];
  logic [`ADDR_W-1:0] m_tgt   [BTB_N];
  logic [`ADDR_W-1:0] pred_hist [8];     // Last fetch prediction per pool pc

  // Model outputs
  logic [`BTB_IDX_W-1:0] f_bidx;
  logic                  f_hit;
  logic [`BHT_IDX_W-1:0] d_hidx;
  logic [`BTB_IDX_W-1:0] d_bidx;
  logic                  is_branch;
  logic                  br_taken;
  logic [`ADDR_W-1:0]    br_target;
  logic                  exp_pred_taken;
  logic [`ADDR_W-1:0]    exp_pred_next_pc;
  logic [`ADDR_W-1:0]    exp_actual_next_pc;
  logic                  exp_redirect;

  always #4 clk = ~clk;  // 8 ns period

  branch_unit u_branch_unit (
    .clk             (clk),
    .rst             (rst),
    .fetch_pc        (fetch_pc),
    .pred_taken      (pred_taken),
    .pred_next_pc    (pred_next_pc),
    .id_valid        (id_valid),
    .id_pc           (id_pc),
    .id_instr        (id_instr),
    .id_flags        (id_flags),
    .id_rs_data      (id_rs_data),
    .id_pred_next_pc (id_pred_next_pc),
    .actual_next_pc  (actual_next_pc),
    .redirect        (redirect)
  );

  branch_checker u_checker (
    .clk                (clk),
    .rst                (rst),
    .pred_taken         (pred_taken),
    .pred_next_pc       (pred_next_pc),
    .actual_next_pc     (actual_next_pc),
    .redirect           (redirect),
    .exp_pred_taken     (exp_pred_taken),
    .exp_pred_next_pc   (exp_pred_next_pc),
    .exp_actual_next_pc (exp_actual_next_pc),
    .exp_redirect       (exp_redirect),
    .err_cnt            (err_cnt),
    .check_cnt          (check_cnt),
    .taken_cnt          (taken_cnt),
    .redirect_cnt       (redirect_cnt)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////////////////////////////////////////
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);  // Galois shift right
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      v          = {v[14:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  // Small address pool, 0x0120 aliases 0x0100 and 0x0144 aliases 0x0104 in the BTB
  function automatic logic [15:0] pool_pc(input logic [2:0] idx);
    case (idx)
      3'd0:    return 16'h0100;
      3'd1:    return 16'h0120;
      3'd2:    return 16'h0104;
      3'd3:    return 16'h0144;
      3'd4:    return 16'h020C;
      3'd5:    return 16'h1F0E;
      3'd6:    return 16'h0306;
      default: return 16'h03F0;
    endcase
  endfunction

  // Taken rule per condition code, flags packed as Z V N
  function automatic logic cond_holds(input logic [2:0] cond, input logic [2:0] f);
    logic z;
    logic v;
    logic n;
    z = f[2];
    v = f[1];
    n = f[0];
    case (cond)
      3'd0:    return !z;                 // NEQ
      3'd1:    return z;                  // EQ
      3'd2:    return !z && !n;           // GT
      3'd3:    return n;                  // LT
      3'd4:    return z || (!z && !n);    // GTE
      3'd5:    return z || n;             // LTE
      3'd6:    return v;                  // OVFL
      default: return 1'b1;               // UNCOND
    endcase
  endfunction

  task automatic drive_decode_cycle();
    logic [15:0] r;
    logic [15:0] fields;
    logic [2:0]  id_idx;
    logic [2:0]  kind;
    logic [3:0]  op;
    take_bits(3, r);
    fetch_idx = r[2:0];
    fetch_pc  = pool_pc(fetch_idx);
    take_bits(3, r);
    id_valid  = (r[2:0] != 3'd0);        // Bubble one cycle in eight
    take_bits(3, r);
    id_idx          = r[2:0];
    id_pc           = pool_pc(id_idx);
    id_pred_next_pc = pred_hist[id_idx];  // What fetch chose last time
    take_bits(3, r);
    kind = r[2:0];
    take_bits(12, fields);
    if (kind < 3'd4) begin
      id_instr = {`OP_B, fields[11:0]};   // cond and imm straight from bits
    end else if (kind < 3'd6) begin
      id_instr = {`OP_BR, fields[11:9], 1'b0, fields[7:4], 4'b0000};
    end else begin
      take_bits(4, r);
      op = r[3:0];
      if (op[3:1] == 3'b110)
        op[3] = 1'b0;                     // Steer away from B and BR
      id_instr = {op, fields[11:0]};
    end
    take_bits(3, r);
    id_flags = r[2:0];
    take_bits(4, r);
    if (r[3]) begin
      id_rs_data = pool_pc(r[2:0]);       // Repeatable BR targets
    end else begin
      take_bits(15, r);
      id_rs_data = {r[14:0], 1'b0};       // Kept even
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    f_bidx = fetch_pc[`BTB_IDX_W:1];
    f_hit  = m_valid[f_bidx] && (m_tag[f_bidx] == fetch_pc[`ADDR_W-1:`BTB_IDX_W+1]);
    exp_pred_taken   = m_cnt[fetch_pc[`BHT_IDX_W:1]][1] && f_hit;
    exp_pred_next_pc = exp_pred_taken ? m_tgt[f_bidx] : fetch_pc + 16'd2;

    d_hidx    = id_pc[`BHT_IDX_W:1];
    d_bidx    = id_pc[`BTB_IDX_W:1];
    is_branch = id_valid && (id_instr[15:12] == `OP_B || id_instr[15:12] == `OP_BR);
    br_taken  = is_branch && cond_holds(id_instr[11:9], id_flags);
    if (id_instr[15:12] == `OP_BR)
      br_target = id_rs_data;
    else
      br_target = id_pc + 16'd2 + 16'($signed({id_instr[8:0], 1'b0}));  // Halfword offset
    exp_actual_next_pc = br_taken ? br_target : id_pc + 16'd2;
    exp_redirect       = is_branch && (exp_actual_next_pc != id_pred_next_pc);
  end

  // Table state moves on the same edge as the DUT
  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < BHT_N; i++)
        m_cnt[i] <= CNT_INIT;
      for (int i = 0; i < BTB_N; i++)
        m_valid[i] <= 1'b0;
      for (int i = 0; i < 8; i++)
        pred_hist[i] <= pool_pc(3'(i)) + 16'd2;  // Nothing fetched yet
    end else begin
      if (is_branch && br_taken && m_cnt[d_hidx] != 2'd3)
        m_cnt[d_hidx] <= m_cnt[d_hidx] + 2'd1;
      else if (is_branch && !br_taken && m_cnt[d_hidx] != 2'd0)
        m_cnt[d_hidx] <= m_cnt[d_hidx] - 2'd1;
      if (br_taken && br_target != id_pred_next_pc) begin
        m_valid[d_bidx] <= 1'b1;
        m_tag[d_bidx]   <= id_pc[`ADDR_W-1:`BTB_IDX_W+1];
        m_tgt[d_bidx]   <= br_target;
      end
      pred_hist[fetch_idx] <= pred_next_pc;  // Recorded for a later decode
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Run control
  ////////////////////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("*** FAILED ***");
      $finish;
    end
  end

  initial begin
    lfsr_state      = LFSR_SEED;
    rst             = 1'b1;
    fetch_idx       = 3'd0;
    fetch_pc        = '0;
    id_valid        = 1'b0;
    id_pc           = '0;
    id_instr        = '0;
    id_flags        = '0;
    id_rs_data      = '0;
    id_pred_next_pc = '0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int c = 0; c < N_CYCLES; c++) begin
      drive_decode_cycle();
      @(negedge clk);
    end
    id_valid = 1'b0;
    $display("Checked cycles %0d, errors %0d, taken predictions %0d, redirects %0d",
             check_cnt, err_cnt, taken_cnt, redirect_cnt);
    if (check_cnt != N_CYCLES)
      $display("Checker saw %0d cycles instead of %0d", check_cnt, N_CYCLES);
    if (taken_cnt == 0)
      $display("No taken prediction seen, the tables never trained");
    if (redirect_cnt == 0)
      $display("No redirect seen in the whole run");
    if (err_cnt == 0 && check_cnt == N_CYCLES && taken_cnt > 0 && redirect_cnt > 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+design
design/branch_pkg.sv
design/branch_history_table.sv
design/branch_target_buffer.sv
design/fetch_predictor.sv
design/branch_control.sv
design/branch_unit.sv
test/branch_checker.sv
test/tb_branch_unit.sv

// File: run_sim.sh
#!/bin/sh
# Build the branch unit testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_branch_unit -f sim.f -o sim_tb || exit 1

out=$(./obj_dir/sim_tb)
echo "$out"

# Status follows the verdict printed by the testbench
echo "$out" | grep -qF '*** PASSED ***' && exit 0 || exit 1
